/* rtl/syscfg_pkg.sv */
package syscfg_pkg;

    // Bus widths
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 16;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int REG_BITS   = 2;
    localparam int TGT_BITS   = 4;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // Host or interconnect toward a target
    typedef struct packed {
        logic  sel;
        logic  enable;
        logic  write;
        addr_t addr;
        data_t wdata;
        strb_t strb;
    } apb_req_t;

    // Target or interconnect toward a host
    typedef struct packed {
        logic  ready;
        data_t rdata;
        logic  slverr;
    } apb_rsp_t;

    // Byte address split into target and register fields
    typedef struct packed {
        logic [ADDR_WIDTH-TGT_BITS-REG_BITS-3:0] unused;
        logic [TGT_BITS-1:0]                     tgt;
        logic [REG_BITS-1:0]                     reg_idx;
        logic [1:0]                              byte_off;
    } apb_addr_fields_t;

    typedef union packed {
        addr_t            raw;
        apb_addr_fields_t fields;
    } apb_addr_u;

    // Maestro commands, also used as the FSM state
    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        RESUME = 4'd1,
        PAUSE  = 4'd2,
        STOP   = 4'd3,
        RESET  = 4'd4
    } action_t;

    // Register indexes inside one target
    localparam logic [REG_BITS-1:0] REG_SR  = 2'd0;
    localparam logic [REG_BITS-1:0] REG_MR  = 2'd1;
    localparam logic [REG_BITS-1:0] REG_BAR = 2'd2;
    localparam logic [REG_BITS-1:0] REG_IER = 2'd3;

endpackage

/* rtl/apb_interconnect.sv */
`timescale 1ns/10ps

module apb_interconnect
    import syscfg_pkg::*;
#(
    parameter int NUM_TARGETS = 3
) (
    input  logic     seq,
    input  logic     reset,

    input  apb_req_t host_req [2],
    output apb_rsp_t host_rsp [2],

    output apb_req_t tgt_req [NUM_TARGETS],
    input  apb_rsp_t tgt_rsp [NUM_TARGETS]
);

    logic busy;
    logic owner;
    logic last_winner;
    logic grant;

    apb_req_t  sel_req;
    apb_rsp_t  sel_rsp;
    apb_addr_u addr_view;
    logic      in_range;
    logic      done;

    logic [NUM_TARGETS-1:0] tgt_sel;

    // Host choice: the owner while busy, otherwise round robin
    always_comb begin
        if (busy) begin
            grant = owner;
        end else if (host_req[0].sel && host_req[1].sel) begin
            grant = ~last_winner;
        end else begin
            grant = host_req[1].sel;
        end
    end

    assign sel_req = host_req[grant];

    // Target and register fields of the granted address
    assign addr_view.raw = sel_req.addr;
    assign in_range      = (int'(addr_view.fields.tgt) < NUM_TARGETS);

    always_comb begin
        for (int i = 0; i < NUM_TARGETS; i++) begin
            tgt_sel[i] = sel_req.sel && in_range && (int'(addr_view.fields.tgt) == i);
        end
    end

    // Same request to every target, sel only on the decoded one
    always_comb begin
        for (int i = 0; i < NUM_TARGETS; i++) begin
            tgt_req[i]     = sel_req;
            tgt_req[i].sel = tgt_sel[i];
        end
    end

    // Response mux, with a local error for a missing target
    always_comb begin
        sel_rsp = '0;
        for (int i = 0; i < NUM_TARGETS; i++) begin
            if (tgt_sel[i]) begin
                sel_rsp = tgt_rsp[i];
            end
        end
        if (!in_range) begin
            sel_rsp.ready  = sel_req.sel && sel_req.enable;
            sel_rsp.slverr = sel_req.sel && sel_req.enable;
        end
    end

    // Losing host sees ready low and keeps its request
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            host_rsp[h] = (grant == h[0]) ? sel_rsp : '0;
        end
    end

    assign done = sel_req.sel && sel_req.enable && sel_rsp.ready;

    always_ff @(posedge seq) begin
        if (reset) begin
            busy        <= 1'b0;
            owner       <= 1'b0;
            // Host 0 wins the first tie
            last_winner <= 1'b1;
        end else if (done) begin
            busy        <= 1'b0;
            last_winner <= grant;
        end else if (!busy && sel_req.sel) begin
            busy  <= 1'b1;
            owner <= grant;
        end
    end

    // Decode never opens two targets at once
    assert property (@(posedge seq) disable iff (reset)
        $onehot0(tgt_sel));

    // Grant is held across the whole transfer
    assert property (@(posedge seq) disable iff (reset)
        busy && !done |=> busy && $stable(owner));

endmodule

/* rtl/target_ctrl.sv */
`timescale 1ns/10ps

module target_ctrl
    import syscfg_pkg::*;
#(
    parameter bit    EN_BOOTSTRAP  = 1'b0,
    parameter addr_t RST_BOOT_ADDR = 16'h0100
) (
    input  logic     seq,
    input  logic     reset,

    input  apb_req_t req,
    output apb_rsp_t rsp,

    input  data_t    irq_vec,
    output logic     irq,

    output logic     rst_out,
    output logic     pause_req,
    input  logic     pause_ack,
    output addr_t    boot_addr
);

    data_t   bar;
    data_t   ier;
    data_t   sr;
    data_t   mr;
    action_t action;
    action_t state;
    logic    paused;
    logic    stopped;

    logic  rsp_ready;
    data_t rsp_rdata;
    logic  rsp_slverr;

    apb_addr_u        addr_view;
    logic [REG_BITS-1:0] reg_idx;
    data_t            mask;
    logic [3:0]       wr_action;
    logic             busy;

    assign sr = {{(DATA_WIDTH-2){1'b0}}, stopped, paused};
    assign mr = {{(DATA_WIDTH-4){1'b0}}, action};

    assign boot_addr = bar[ADDR_WIDTH-1:0];

    // Any enabled source raises the line
    assign irq = |(ier & irq_vec);

    assign addr_view.raw = req.addr;
    assign reg_idx       = addr_view.fields.reg_idx;

    // Byte strobes widened to a bit mask
    always_comb begin
        for (int i = 0; i < STRB_WIDTH; i++) begin
            mask[i*8 +: 8] = req.strb[i] ? 8'hFF : 8'h00;
        end
    end

    assign wr_action = req.wdata[3:0] & mask[3:0];
    assign busy      = (state != IDLE) || (action != IDLE);

    assign rsp.ready  = rsp_ready;
    assign rsp.rdata  = rsp_rdata;
    assign rsp.slverr = rsp_slverr;

    // APB side
    always_ff @(posedge seq) begin
        if (reset) begin
            action     <= IDLE;
            bar        <= {{(DATA_WIDTH-ADDR_WIDTH){1'b0}}, RST_BOOT_ADDR};
            ier        <= '0;
            rsp_ready  <= 1'b0;
            rsp_rdata  <= '0;
            rsp_slverr <= 1'b0;
        end else if (req.sel && !rsp_ready) begin
            rsp_ready <= 1'b1;
            case (reg_idx)
                REG_SR: begin
                    // Status is read-only
                    if (req.write) begin
                        rsp_slverr <= 1'b1;
                    end else begin
                        rsp_rdata <= sr;
                    end
                end
                REG_MR: begin
                    if (!req.write) begin
                        rsp_rdata <= mr;
                    end else if (busy) begin
                        rsp_slverr <= 1'b1;
                    end else if (wr_action <= 4'(RESET)) begin
                        action <= action_t'(wr_action);
                    end else begin
                        // Unknown codes do nothing
                        action <= IDLE;
                    end
                end
                REG_BAR: begin
                    if (!req.write) begin
                        rsp_rdata <= bar;
                    end else if (busy) begin
                        rsp_slverr <= 1'b1;
                    end else begin
                        bar <= (req.wdata & mask) | (bar & ~mask);
                    end
                end
                default: begin
                    // IER
                    if (req.write) begin
                        ier <= (req.wdata & mask) | (ier & ~mask);
                    end else begin
                        rsp_rdata <= ier;
                    end
                end
            endcase
        end else if (req.sel && req.enable && rsp_ready) begin
            // Transfer done, command already taken by the FSM
            rsp_ready  <= 1'b0;
            rsp_rdata  <= '0;
            rsp_slverr <= 1'b0;
            action     <= IDLE;
        end
    end

    // Maestro FSM
    always_ff @(posedge seq) begin
        if (reset) begin
            rst_out   <= 1'b1;
            pause_req <= 1'b1;
            state     <= EN_BOOTSTRAP ? RESUME : IDLE;
            paused    <= 1'b1;
            stopped   <= 1'b1;
        end else begin
            case (state)
                RESUME: begin
                    rst_out   <= 1'b0;
                    pause_req <= 1'b0;
                    // Target has dropped its ack
                    if (!pause_req && !pause_ack) begin
                        paused  <= 1'b0;
                        stopped <= 1'b0;
                        state   <= IDLE;
                    end
                end
                PAUSE: begin
                    pause_req <= 1'b1;
                    if (pause_req && pause_ack) begin
                        paused <= 1'b1;
                        state  <= IDLE;
                    end
                end
                STOP, RESET: begin
                    pause_req <= 1'b1;
                    // Reset only once the target is quiet
                    if (pause_req && pause_ack) begin
                        rst_out <= 1'b1;
                        paused  <= 1'b1;
                        stopped <= 1'b1;
                        state   <= (state == RESET) ? RESUME : IDLE;
                    end
                end
                default: begin
                    state <= action;
                end
            endcase
        end
    end

    // Ready only inside an access phase from the host
    assert property (@(posedge seq) disable iff (reset)
        rsp_ready |-> req.sel && req.enable);

    // Reset reaches a target only while it is held paused
    assert property (@(posedge seq) disable iff (reset)
        rst_out |-> pause_req);

endmodule

/* rtl/syscfg_top.sv */
`timescale 1ns/10ps

module syscfg_top
    import syscfg_pkg::*;
#(
    parameter int                     NUM_TARGETS    = 3,
    parameter logic [NUM_TARGETS-1:0] BOOTSTRAP_MASK = '0,
    parameter addr_t                  RST_BOOT_ADDR  = 16'h0100
) (
    input  logic                   seq,
    input  logic                   reset,

    input  apb_req_t               host_req [2],
    output apb_rsp_t               host_rsp [2],

    input  data_t                  irq_vec [NUM_TARGETS],

    output logic [NUM_TARGETS-1:0] tgt_rst,
    output logic [NUM_TARGETS-1:0] tgt_pause_req,
    input  logic [NUM_TARGETS-1:0] tgt_pause_ack,
    output logic [NUM_TARGETS-1:0] tgt_irq,
    output addr_t                  tgt_boot_addr [NUM_TARGETS]
);

    apb_req_t tgt_req [NUM_TARGETS];
    apb_rsp_t tgt_rsp [NUM_TARGETS];

    apb_interconnect #(
        .NUM_TARGETS (NUM_TARGETS)
    ) u_interconnect (
        .seq      (seq),
        .reset    (reset),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .tgt_req  (tgt_req),
        .tgt_rsp  (tgt_rsp)
    );

    // One controller per target, bootstrap picked from the mask
    for (genvar i = 0; i < NUM_TARGETS; i++) begin : g_tgt
        target_ctrl #(
            .EN_BOOTSTRAP  (BOOTSTRAP_MASK[i]),
            .RST_BOOT_ADDR (RST_BOOT_ADDR)
        ) u_target_ctrl (
            .seq       (seq),
            .reset     (reset),
            .req       (tgt_req[i]),
            .rsp       (tgt_rsp[i]),
            .irq_vec   (irq_vec[i]),
            .irq       (tgt_irq[i]),
            .rst_out   (tgt_rst[i]),
            .pause_req (tgt_pause_req[i]),
            .pause_ack (tgt_pause_ack[i]),
            .boot_addr (tgt_boot_addr[i])
        );
    end

endmodule

/* testbench/tb_target_model.sv */
`timescale 1ns/10ps

// Behavioral processing target, answers the pause handshake late
module tb_target_model (
    input  logic       seq,
    input  logic       reset,
    input  logic       pause_req,
    input  logic       hold,
    input  logic [3:0] delay,
    output logic       pause_ack
);

    logic [3:0] count;

    always @(posedge seq) begin
        if (reset) begin
            // Target comes out of reset already paused
            pause_ack <= 1'b1;
            count     <= '0;
        end else if (hold || (pause_ack == pause_req)) begin
            count <= '0;
        end else if (count >= delay) begin
            pause_ack <= pause_req;
            count     <= '0;
        end else begin
            count <= count + 4'd1;
        end
    end

endmodule

/* testbench/tb_syscfg.sv */
`timescale 1ns/10ps

module tb_syscfg
    import syscfg_pkg::*;
();

    localparam int    NUM_TGT     = 3;
    localparam addr_t BOOT_ADDR   = 16'h0100;
    localparam int    NUM_TESTS   = 6;
    localparam int    TEST_CYCLES = 2000;

    logic               seq = 1'b0;
    logic               reset;
    apb_req_t           host_req [2];
    apb_rsp_t           host_rsp [2];
    data_t              irq_vec [NUM_TGT];
    logic [NUM_TGT-1:0] tgt_rst;
    logic [NUM_TGT-1:0] tgt_pause_req;
    logic [NUM_TGT-1:0] tgt_pause_ack;
    logic [NUM_TGT-1:0] tgt_irq;
    addr_t              tgt_boot_addr [NUM_TGT];
    logic [NUM_TGT-1:0] ack_hold;
    logic [3:0]         ack_delay [NUM_TGT];

    // Expected register contents
    data_t ref_bar [NUM_TGT];
    data_t ref_ier [NUM_TGT];
    data_t ref_sr  [NUM_TGT];

    string chk_name [$];
    data_t chk_exp [$];
    data_t chk_act [$];

    int          checks = 0;
    int          errors = 0;
    int          errs_before;
    int          test_num;
    int          done_cnt [2];
    data_t       arb_data [2][6];
    logic [15:0] lfsr_state;
    int          t;
    logic [1:0]  r;
    data_t       wd;
    data_t       vec;
    strb_t       st;

    syscfg_top #(
        .NUM_TARGETS    (NUM_TGT),
        .BOOTSTRAP_MASK (3'b001),
        .RST_BOOT_ADDR  (BOOT_ADDR)
    ) dut (
        .seq           (seq),
        .reset         (reset),
        .host_req      (host_req),
        .host_rsp      (host_rsp),
        .irq_vec       (irq_vec),
        .tgt_rst       (tgt_rst),
        .tgt_pause_req (tgt_pause_req),
        .tgt_pause_ack (tgt_pause_ack),
        .tgt_irq       (tgt_irq),
        .tgt_boot_addr (tgt_boot_addr)
    );

    for (genvar i = 0; i < NUM_TGT; i++) begin : g_model
        tb_target_model u_model (
            .seq       (seq),
            .reset     (reset),
            .pause_req (tgt_pause_req[i]),
            .hold      (ack_hold[i]),
            .delay     (ack_delay[i]),
            .pause_ack (tgt_pause_ack[i])
        );
    end

    always #10 seq = ~seq;

    // Taps 16, 14, 13, 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[0] ^ lfsr_state[2] ^ lfsr_state[3] ^ lfsr_state[5];
        lfsr_state = {fb, lfsr_state[15:1]};
        return fb;
    endfunction

    function automatic data_t rand_bits(input int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[DATA_WIDTH-2:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic addr_t make_addr(input int tgt, input logic [1:0] idx);
        apb_addr_u a;
        a.raw            = '0;
        a.fields.tgt     = tgt[TGT_BITS-1:0];
        a.fields.reg_idx = idx;
        return a.raw;
    endfunction

    function automatic data_t merge_bytes(input data_t old_v, input data_t new_v,
                                          input strb_t strb);
        data_t v;
        v = old_v;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb[i]) begin
                v[i*8 +: 8] = new_v[i*8 +: 8];
            end
        end
        return v;
    endfunction

    function automatic data_t ref_read(input int tgt, input logic [1:0] idx,
                                       output logic err);
        data_t v;
        err = (tgt >= NUM_TGT);
        v   = '0;
        if (!err) begin
            case (idx)
                REG_SR:  v = ref_sr[tgt];
                REG_BAR: v = ref_bar[tgt];
                REG_IER: v = ref_ier[tgt];
                // MR is back to IDLE once a transfer has ended
                default: v = '0;
            endcase
        end
        return v;
    endfunction

    task automatic check_value(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %08h, actual %08h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic expect_value(input string name, input data_t exp, input data_t act);
        chk_name.push_back(name);
        chk_exp.push_back(exp);
        chk_act.push_back(act);
    endtask

    // Comparison process
    always @(negedge seq) begin
        while (chk_exp.size() > 0) begin
            check_value(chk_name.pop_front(), chk_exp.pop_front(), chk_act.pop_front());
        end
    end

    // One APB transfer, entered and left 1 ns after a rising edge
    task automatic apb_xfer(input int h, input logic wr, input int tgt, input logic [1:0] idx,
                            input data_t wdata, input strb_t strb,
                            output data_t rdata, output logic err);
        apb_req_t rq;
        rq.sel    = 1'b1;
        rq.enable = 1'b0;
        rq.write  = wr;
        rq.addr   = make_addr(tgt, idx);
        rq.wdata  = wdata;
        rq.strb   = wr ? strb : '0;
        host_req[h] = rq;
        @(posedge seq);
        #1;
        host_req[h].enable = 1'b1;
        @(negedge seq);
        while (!host_rsp[h].ready) begin
            @(negedge seq);
        end
        rdata = host_rsp[h].rdata;
        err   = host_rsp[h].slverr;
        @(posedge seq);
        #1;
        host_req[h] = '0;
    endtask

    task automatic apb_write(input int h, input int tgt, input logic [1:0] idx,
                             input data_t wdata, input strb_t strb, input logic exp_err);
        data_t rdata;
        logic  err;
        apb_xfer(h, 1'b1, tgt, idx, wdata, strb, rdata, err);
        expect_value($sformatf("host_rsp[%0d].slverr", h), data_t'(exp_err), data_t'(err));
        if (!exp_err && idx == REG_BAR) begin
            ref_bar[tgt] = merge_bytes(ref_bar[tgt], wdata, strb);
        end
        if (!exp_err && idx == REG_IER) begin
            ref_ier[tgt] = merge_bytes(ref_ier[tgt], wdata, strb);
        end
    endtask

    task automatic read_check(input int h, input int tgt, input logic [1:0] idx);
        data_t rdata;
        data_t exp;
        logic  err;
        logic  exp_err;
        apb_xfer(h, 1'b0, tgt, idx, '0, '0, rdata, err);
        exp = ref_read(tgt, idx, exp_err);
        expect_value($sformatf("host_rsp[%0d].rdata", h), exp, rdata);
        expect_value($sformatf("host_rsp[%0d].slverr", h), data_t'(exp_err), data_t'(err));
    endtask

    // Maestro timing varies, so SR is read until it settles
    task automatic poll_sr(input int h, input int tgt);
        data_t rdata;
        data_t exp;
        logic  err;
        logic  exp_err;
        int    tries;
        exp   = ref_read(tgt, REG_SR, exp_err);
        rdata = ~exp;
        tries = 0;
        while (rdata !== exp && tries < 50) begin
            apb_xfer(h, 1'b0, tgt, REG_SR, '0, '0, rdata, err);
            tries++;
        end
        expect_value($sformatf("host_rsp[%0d].rdata", h), exp, rdata);
    endtask

    task automatic end_test(input string name);
        repeat (2) @(negedge seq);
        test_num++;
        if (errors == errs_before) begin
            $display("Test %0d %s: ok", test_num, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_num, name, errors - errs_before);
        end
        errs_before = errors;
        @(posedge seq);
        #1;
    endtask

    task automatic run_host(input int h, input int tgt);
        logic [1:0] idx;
        for (int i = 0; i < 6; i++) begin
            idx = i[0] ? REG_BAR : REG_IER;
            apb_write(h, tgt, idx, arb_data[h][i], 4'hF, 1'b0);
            read_check(h, tgt, idx);
            done_cnt[h]++;
        end
    endtask

    initial begin
        lfsr_state  = 16'd32327;
        reset       = 1'b1;
        host_req[0] = '0;
        host_req[1] = '0;
        ack_hold    = '0;
        errs_before = 0;
        test_num    = 0;
        done_cnt[0] = 0;
        done_cnt[1] = 0;
        for (int i = 0; i < NUM_TGT; i++) begin
            irq_vec[i]   = '0;
            ack_delay[i] = 4'(rand_bits(3)) + 4'd1;
            ref_bar[i]   = {16'h0000, BOOT_ADDR};
            ref_ier[i]   = '0;
            ref_sr[i]    = (i == 0) ? 32'h0 : 32'h3;
        end
        repeat (2) @(posedge seq);
        #1;
        reset = 1'b0;

        read_check(0, 1, REG_SR);
        read_check(0, 2, REG_SR);
        expect_value("tgt_rst[2:1]", 32'h3, data_t'(tgt_rst[2:1]));
        poll_sr(0, 0);
        expect_value("tgt_rst", 32'h6, data_t'(tgt_rst));
        for (int i = 0; i < NUM_TGT; i++) begin
            read_check(0, i, REG_BAR);
            read_check(0, i, REG_IER);
            read_check(0, i, REG_MR);
        end
        end_test("reset and bootstrap");

        for (int i = 0; i < 8; i++) begin
            t  = int'(rand_bits(2)) % NUM_TGT;
            r  = (rand_bits(1) == 32'd1) ? REG_IER : REG_BAR;
            wd = rand_bits(32);
            st = strb_t'(rand_bits(4));
            apb_write(1, t, r, wd, st, 1'b0);
            read_check(1, t, r);
            expect_value("tgt_boot_addr", data_t'(ref_bar[t][15:0]),
                         data_t'(tgt_boot_addr[t]));
        end
        apb_write(1, 1, REG_SR, 32'h3, 4'hF, 1'b1);
        apb_write(1, 5, REG_BAR, rand_bits(32), 4'hF, 1'b1);
        // Ack stuck high keeps target 2 inside RESUME
        ack_hold[2] = 1'b1;
        apb_write(1, 2, REG_MR, data_t'(RESUME), 4'hF, 1'b0);
        apb_write(1, 2, REG_BAR, rand_bits(32), 4'hF, 1'b1);
        read_check(1, 2, REG_BAR);
        ack_hold[2] = 1'b0;
        ref_sr[2]   = 32'h0;
        poll_sr(1, 2);
        end_test("register access");

        apb_write(0, 1, REG_MR, data_t'(RESUME), 4'hF, 1'b0);
        ref_sr[1] = 32'h0;
        poll_sr(0, 1);
        expect_value("tgt_rst[1]", 32'h0, data_t'(tgt_rst[1]));
        expect_value("tgt_pause_req[1]", 32'h0, data_t'(tgt_pause_req[1]));
        apb_write(0, 1, REG_MR, data_t'(PAUSE), 4'hF, 1'b0);
        ref_sr[1] = 32'h1;
        poll_sr(0, 1);
        apb_write(0, 1, REG_MR, data_t'(STOP), 4'hF, 1'b0);
        ref_sr[1] = 32'h3;
        poll_sr(0, 1);
        expect_value("tgt_rst[1]", 32'h1, data_t'(tgt_rst[1]));
        apb_write(0, 1, REG_MR, data_t'(RESET), 4'hF, 1'b0);
        ref_sr[1] = 32'h0;
        poll_sr(0, 1);
        expect_value("tgt_rst[1]", 32'h0, data_t'(tgt_rst[1]));
        end_test("maestro sequence");

        ack_hold[1] = 1'b1;
        apb_write(1, 1, REG_MR, data_t'(PAUSE), 4'hF, 1'b0);
        apb_write(1, 1, REG_MR, data_t'(RESUME), 4'hF, 1'b1);
        apb_write(1, 1, REG_BAR, rand_bits(32), 4'hF, 1'b1);
        read_check(1, 1, REG_BAR);
        ack_hold[1] = 1'b0;
        ref_sr[1]   = 32'h1;
        poll_sr(1, 1);
        end_test("busy rule");

        for (int i = 0; i < 6; i++) begin
            t   = i % NUM_TGT;
            wd  = rand_bits(32);
            vec = rand_bits(32);
            // Odd rounds hit only masked sources
            if (i[0]) begin
                vec = vec & ~wd;
            end
            apb_write(0, t, REG_IER, wd, 4'hF, 1'b0);
            irq_vec[t] = vec;
            @(negedge seq);
            expect_value("tgt_irq", data_t'(|(ref_ier[t] & vec)), data_t'(tgt_irq[t]));
            @(posedge seq);
            #1;
        end
        end_test("interrupts");

        for (int h = 0; h < 2; h++) begin
            for (int i = 0; i < 6; i++) begin
                arb_data[h][i] = rand_bits(32);
            end
        end
        fork
            run_host(0, 0);
            run_host(1, 2);
        join_any
        // Round robin leaves the other host one transfer behind
        expect_value("done_cnt[0] + done_cnt[1]", 32'd11,
                     data_t'(done_cnt[0] + done_cnt[1]));
        wait (done_cnt[0] == 6 && done_cnt[1] == 6);
        end_test("arbitration");

        $display("Tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge seq);
        $display("Watchdog expired after %0d cycles with tests still running",
                 NUM_TESTS * TEST_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

/* sim.f */
rtl/syscfg_pkg.sv
rtl/apb_interconnect.sv
rtl/target_ctrl.sv
rtl/syscfg_top.sv
testbench/tb_target_model.sv
testbench/tb_syscfg.sv

/* Makefile */
SIM := obj_dir/Vtb_syscfg

.PHONY: all run clean

all: run

$(SIM): sim.f $(wildcard rtl/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert --top-module tb_syscfg -f sim.f -o Vtb_syscfg

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
